//--- led_pkg.sv
// shared types and constants for the status LED subsystem
package led_pkg;

  // ------------------------------
  // vector types
  // ------------------------------

  typedef logic [7:0]  cluster_count_t;  // clusters seen in one cycle
  typedef logic [31:0] rate_t;           // clusters summed over one window
  typedef logic [15:0] led_word_t;       // full front-panel word
  typedef logic [7:0]  bar_t;            // thermometer bar, also cylon byte

  // display mode, listed in priority order
  typedef enum logic [1:0] {
    mode_error,    // clock manager unlocked
    mode_no_link,  // link not receiving
    mode_cylon,    // waiting for first cluster of the run
    mode_normal    // status flashes and rate bar
  } led_mode_e;

  // ------------------------------
  // event flash
  // ------------------------------

  // stretched flash length in cycles
  localparam int unsigned flash_cycles = 16;
  // must hold flash_cycles itself
  localparam int unsigned flash_cnt_w  = 5;

  // ------------------------------
  // rate meter
  // ------------------------------

  // measuring window, kept a power of two so the counter wraps on its own
  localparam int unsigned rate_window_cycles = 256;
  // lowest bar segment threshold, segment i at bar_base << i
  localparam rate_t       bar_base           = 32'd4;

  // ------------------------------
  // animations
  // ------------------------------

  localparam int unsigned blink_div_bits = 4;   // heartbeat toggles every 16 cycles
  localparam int unsigned fader_bits     = 10;  // ramp counter, top bit picks up or down
  localparam int unsigned cylon_div_bits = 3;   // one scan step every 8 cycles

  // error display, alternates with its inverse
  localparam led_word_t error_pattern = 16'h00ff;

endpackage

//--- led_flash_if.sv
`timescale 1ns/10ps

// stretched flash levels, one per event source
interface led_flash_if;

  logic l1a;         // trigger accept
  logic bc0;         // bunch counter zero
  logic resync;      // ttc resync
  logic vfat_reset;  // front-end reset
  logic gbt_req;     // request seen on the link

  // flash stretcher side
  modport source (
    output l1a, bc0, resync, vfat_reset, gbt_req
  );

  // display side
  modport sink (
    input l1a, bc0, resync, vfat_reset, gbt_req
  );

endinterface

//--- event_flash.sv
`timescale 1ns/10ps

// turns single-cycle event strobes into flash levels long enough to see
module event_flash (
  input  logic        clock,
  input  logic        rst_n,
  input  logic        ttc_l1a,
  input  logic        ttc_bc0,
  input  logic        ttc_resync,
  input  logic        vfat_reset,
  input  logic        gbt_request_received,
  led_flash_if.source flash
);

  // ------------------------------
  // channel packing
  // ------------------------------

  // bit order: l1a, bc0, resync, vfat_reset, gbt_req
  logic [4:0] strobe;
  logic [4:0] flash_on;

  // one down-counter per channel
  logic [led_pkg::flash_cnt_w-1:0] flash_cnt [5];

  assign strobe = {gbt_request_received, vfat_reset, ttc_resync, ttc_bc0, ttc_l1a};

  // ------------------------------
  // stretch counters
  // ------------------------------

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < $bits(strobe); i++) begin
        flash_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < $bits(strobe); i++) begin
        if (strobe[i]) begin
          // new strobe restarts the flash even if still lit
          flash_cnt[i] <= led_pkg::flash_cnt_w'(led_pkg::flash_cycles);
        end else if (flash_cnt[i] != '0) begin
          flash_cnt[i] <= flash_cnt[i] - 1'b1;  // run down to dark
        end
      end
    end
  end

  // lit while any count remains
  always_comb begin
    for (int i = 0; i < $bits(strobe); i++) begin
      flash_on[i] = (flash_cnt[i] != '0);
    end
  end

  // ------------------------------
  // outputs to the display
  // ------------------------------

  assign flash.l1a        = flash_on[0];
  assign flash.bc0        = flash_on[1];
  assign flash.resync     = flash_on[2];
  assign flash.vfat_reset = flash_on[3];
  assign flash.gbt_req    = flash_on[4];

endmodule

//--- rate_meter.sv
`timescale 1ns/10ps

// cluster rate over a fixed window, plus a log-scale bar of it
module rate_meter (
  input  logic                    clock,
  input  logic                    rst_n,
  input  led_pkg::cluster_count_t cluster_count,
  output led_pkg::rate_t          cluster_rate,
  output led_pkg::bar_t           bar
);

  // ------------------------------
  // log thermometer
  // ------------------------------

  // segment i lit once rate reaches bar_base << i
  function automatic led_pkg::bar_t thermo(input led_pkg::rate_t rate);
    led_pkg::bar_t seg;
    for (int i = 0; i < $bits(led_pkg::bar_t); i++) begin
      seg[i] = (rate >= (led_pkg::bar_base << i));
    end
    return seg;
  endfunction

  // ------------------------------
  // state
  // ------------------------------

  led_pkg::cluster_count_t cc_q;  // input register

  // free-running, wraps once per window
  logic [$clog2(led_pkg::rate_window_cycles)-1:0] win_cnt;

  led_pkg::rate_t win_sum;   // running sum in the current window
  led_pkg::rate_t sum_next;  // sum including this cycle
  logic           win_last;  // final cycle of the window

  assign sum_next = win_sum + led_pkg::rate_t'(cc_q);
  assign win_last = &win_cnt;  // power-of-two window

  // ------------------------------
  // input register
  // ------------------------------

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      cc_q <= '0;
    end else begin
      cc_q <= cluster_count;
    end
  end

  // ------------------------------
  // window counter and accumulator
  // ------------------------------

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      win_cnt <= '0;
      win_sum <= '0;
    end else begin
      win_cnt <= win_cnt + 1'b1;
      if (win_last) begin
        win_sum <= '0;  // fresh window next cycle
      end else begin
        win_sum <= sum_next;
      end
    end
  end

  // ------------------------------
  // result registers
  // ------------------------------

  // both update together at window end and hold in between
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      cluster_rate <= '0;
      bar          <= '0;
    end else if (win_last) begin
      cluster_rate <= sum_next;          // last sample goes in too
      bar          <= thermo(sum_next);
    end
  end

endmodule

//--- blink_gen.sv
`timescale 1ns/10ps

// heartbeat blink, pwm fader and cylon scan for the panel
module blink_gen (
  input  logic          clock,
  input  logic          rst_n,
  output logic          heartbeat,
  output logic          fader,
  output led_pkg::bar_t cylon
);

  // ------------------------------
  // heartbeat
  // ------------------------------

  logic [led_pkg::blink_div_bits-1:0] hb_cnt;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      hb_cnt    <= '0;
      heartbeat <= 1'b0;
    end else begin
      hb_cnt <= hb_cnt + 1'b1;
      if (&hb_cnt) heartbeat <= ~heartbeat;  // toggle on wrap
    end
  end

  // ------------------------------
  // fader
  // ------------------------------

  logic [led_pkg::fader_bits-1:0] fade_cnt;  // slow ramp
  logic [3:0]                     level;     // 16 brightness steps
  logic [4:0]                     pwm_acc;   // sigma-delta accumulator, carry is the output

  // top bit picks direction, next four bits the brightness
  assign level = fade_cnt[led_pkg::fader_bits-1] ?
                 ~fade_cnt[led_pkg::fader_bits-2 -: 4] :
                  fade_cnt[led_pkg::fader_bits-2 -: 4];

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      fade_cnt <= '0;
      pwm_acc  <= '0;
    end else begin
      fade_cnt <= fade_cnt + 1'b1;
      pwm_acc  <= {1'b0, pwm_acc[3:0]} + {1'b0, level};  // carry density tracks level
    end
  end

  assign fader = pwm_acc[4];

  // ------------------------------
  // cylon
  // ------------------------------

  logic [led_pkg::cylon_div_bits-1:0] cyl_cnt;
  logic                               cyl_up;  // moving toward bit 7

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      cyl_cnt <= '0;
      cyl_up  <= 1'b1;
      cylon   <= 8'h01;  // start at the right end
    end else begin
      cyl_cnt <= cyl_cnt + 1'b1;
      if (&cyl_cnt) begin
        if (cyl_up) begin
          if (cylon[7]) begin
            cyl_up <= 1'b0;           // bounce off the top
            cylon  <= cylon >> 1;
          end else begin
            cylon <= cylon << 1;
          end
        end else begin
          if (cylon[0]) begin
            cyl_up <= 1'b1;           // bounce off the bottom
            cylon  <= cylon << 1;
          end else begin
            cylon <= cylon >> 1;
          end
        end
      end
    end
  end

endmodule

//--- led_select.sv
`timescale 1ns/10ps

// picks the display mode and registers the panel word
module led_select (
  input  logic                    clock,
  input  logic                    rst_n,
  input  logic                    mmcm_locked,
  input  logic                    gbt_rxready,
  input  logic                    gbt_rxvalid,
  input  logic                    gbt_link_ready,
  input  logic                    ttc_resync,
  input  led_pkg::cluster_count_t cluster_count,
  led_flash_if.sink               flash,
  input  led_pkg::bar_t           bar,
  input  logic                    heartbeat,
  input  logic                    fader,
  input  led_pkg::bar_t           cylon,
  output led_pkg::led_word_t      led_out
);

  logic               first_seen;  // cluster seen this run
  led_pkg::led_mode_e mode;
  logic [7:0]         status_hi;   // normal high byte, shared with cylon
  led_pkg::led_word_t led_next;

  // ------------------------------
  // first cluster of the run
  // ------------------------------

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      first_seen <= 1'b0;
    end else if (ttc_resync) begin
      first_seen <= 1'b0;  // new run, back to the scanner
    end else if (cluster_count != '0) begin
      first_seen <= 1'b1;
    end
  end

  // ------------------------------
  // mode priority
  // ------------------------------

  always_comb begin
    if (!mmcm_locked)                     mode = led_pkg::mode_error;
    else if (!gbt_rxready || !gbt_rxvalid) mode = led_pkg::mode_no_link;
    else if (!first_seen)                 mode = led_pkg::mode_cylon;
    else                                  mode = led_pkg::mode_normal;
  end

  // link status and event flashes, bit 15 down to 8
  assign status_hi = {gbt_link_ready & heartbeat,
                      heartbeat,
                      gbt_link_ready & fader,
                      flash.gbt_req,
                      flash.l1a,
                      flash.resync,
                      flash.bc0,
                      flash.vfat_reset};

  // ------------------------------
  // word build and output register
  // ------------------------------

  always_comb begin
    case (mode)
      led_pkg::mode_error:   led_next = heartbeat ? ~led_pkg::error_pattern
                                                  :  led_pkg::error_pattern;
      led_pkg::mode_no_link: led_next = {16{fader}};        // whole panel breathes
      led_pkg::mode_cylon:   led_next = {status_hi, cylon};
      default:               led_next = {status_hi, bar};   // normal
    endcase
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) led_out <= '0;
    else        led_out <= led_next;
  end

endmodule

//--- led_control.sv
`timescale 1ns/10ps

// front-panel LED subsystem, top level
module led_control (
  input  logic                    clock,
  input  logic                    rst_n,
  input  logic                    mmcm_locked,
  input  logic                    ttc_l1a,
  input  logic                    ttc_bc0,
  input  logic                    ttc_resync,
  input  logic                    vfat_reset,
  input  logic                    gbt_rxready,
  input  logic                    gbt_rxvalid,
  input  logic                    gbt_link_ready,
  input  logic                    gbt_request_received,
  input  led_pkg::cluster_count_t cluster_count,
  output led_pkg::rate_t          cluster_rate,
  output led_pkg::led_word_t      led_out
);

  // ------------------------------
  // stage links
  // ------------------------------

  led_flash_if   flash_bus ();  // decode to result
  led_pkg::bar_t bar;           // rate bar
  logic          heartbeat;
  logic          fader;
  led_pkg::bar_t cylon;

  // decode
  event_flash u_event_flash (
    .clock                (clock),
    .rst_n                (rst_n),
    .ttc_l1a              (ttc_l1a),
    .ttc_bc0              (ttc_bc0),
    .ttc_resync           (ttc_resync),
    .vfat_reset           (vfat_reset),
    .gbt_request_received (gbt_request_received),
    .flash                (flash_bus.source)
  );

  // execute
  rate_meter u_rate_meter (
    .clock         (clock),
    .rst_n         (rst_n),
    .cluster_count (cluster_count),
    .cluster_rate  (cluster_rate),
    .bar           (bar)
  );

  blink_gen u_blink_gen (
    .clock     (clock),
    .rst_n     (rst_n),
    .heartbeat (heartbeat),
    .fader     (fader),
    .cylon     (cylon)
  );

  // result
  led_select u_led_select (
    .clock          (clock),
    .rst_n          (rst_n),
    .mmcm_locked    (mmcm_locked),
    .gbt_rxready    (gbt_rxready),
    .gbt_rxvalid    (gbt_rxvalid),
    .gbt_link_ready (gbt_link_ready),
    .ttc_resync     (ttc_resync),
    .cluster_count  (cluster_count),
    .flash          (flash_bus.sink),
    .bar            (bar),
    .heartbeat      (heartbeat),
    .fader          (fader),
    .cylon          (cylon),
    .led_out        (led_out)
  );

endmodule

//--- led_control_assertions.sv
`timescale 1ns/10ps

// concurrent checks on the panel word, bound onto led_control
module led_control_assertions (
  input logic                    clock,
  input logic                    rst_n,
  input logic                    mmcm_locked,
  input logic                    gbt_rxready,
  input logic                    gbt_rxvalid,
  input logic                    ttc_l1a,
  input logic                    ttc_bc0,
  input logic                    ttc_resync,
  input logic                    vfat_reset,
  input logic                    gbt_request_received,
  input led_pkg::cluster_count_t cluster_count,
  input led_pkg::led_word_t      led_out
);

  int unsigned fail_count = 0;  // assertion failures so far

  logic       link_up;   // clock locked and link receiving
  logic       seen_q;    // a cluster arrived since reset or resync
  logic [4:0] strobe;    // gbt_req, vfat_reset, resync, bc0, l1a
  logic [4:0] lit;       // matching led bits 12, 8, 10, 9, 11
  logic [4:0] want_lit;  // flash must be visible now
  logic [4:0] idle;      // no flash owed, led must be dark

  // cycles until the flash stops being owed, per strobe
  logic [led_pkg::flash_cnt_w-1:0] due [5];

  assign link_up = mmcm_locked && gbt_rxready && gbt_rxvalid;
  assign strobe  = {gbt_request_received, vfat_reset, ttc_resync, ttc_bc0, ttc_l1a};
  assign lit     = {led_out[12], led_out[8], led_out[10], led_out[9], led_out[11]};

  // ------------------------------
  // reference state
  // ------------------------------

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      seen_q <= 1'b0;
    end else if (ttc_resync) begin
      seen_q <= 1'b0;                                      // new run
    end else if (cluster_count != '0) begin
      seen_q <= 1'b1;
    end
  end

  // one spare count so the first visible edge is two after the strobe
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 5; i++) begin
        due[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 5; i++) begin
        if (strobe[i]) begin
          due[i] <= led_pkg::flash_cnt_w'(led_pkg::flash_cycles + 1);
        end else if (due[i] != '0) begin
          due[i] <= due[i] - 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < 5; i++) begin
      want_lit[i] = (due[i] != '0) &&
                    (due[i] <= led_pkg::flash_cnt_w'(led_pkg::flash_cycles));
      idle[i]     = (due[i] == '0);
    end
  end

  // ------------------------------
  // checks
  // ------------------------------

  error_shown: assert property (@(posedge clock) disable iff (!rst_n)
    !mmcm_locked |=> (led_out == led_pkg::error_pattern || led_out == ~led_pkg::error_pattern))
    else begin
      fail_count++;
      $error("led_out is not the error pattern while the clock manager is unlocked");
    end

  no_link_uniform: assert property (@(posedge clock) disable iff (!rst_n)
    (mmcm_locked && !(gbt_rxready && gbt_rxvalid)) |=> (led_out == '0 || led_out == '1))
    else begin
      fail_count++;
      $error("led_out bits differ while the link is down");
    end

  cylon_one_hot: assert property (@(posedge clock) disable iff (!rst_n)
    (link_up && !seen_q) |=> $onehot(led_out[7:0]))
    else begin
      fail_count++;
      $error("led_out low byte is not one-hot before the first cluster");
    end

  // status byte is on the panel whenever the link was up one edge before
  flash_visible: assert property (@(posedge clock) disable iff (!rst_n)
    link_up |=> ((want_lit & ~lit) == '0))
    else begin
      fail_count++;
      $error("an event flash led went dark too early or never lit");
    end

  flash_dark: assert property (@(posedge clock) disable iff (!rst_n)
    link_up |=> ((idle & lit) == '0))
    else begin
      fail_count++;
      $error("an event flash led stayed lit with no recent strobe");
    end

endmodule

//--- tb_led_control.sv
`timescale 1ns/10ps

module tb_led_control;

  // ------------------------------
  // run length
  // ------------------------------

  localparam int unsigned clock_period  = 8;
  localparam int unsigned reset_cycles  = 5;
  localparam int unsigned error_cycles  = 40;   // spans a few heartbeat toggles
  localparam int unsigned nolink_cycles = 20;   // per missing link signal
  localparam int unsigned cylon_cycles  = 80;   // more than one full sweep
  localparam int unsigned strobe_count  = 24;
  localparam int unsigned max_gap       = 24;
  localparam int unsigned rate_rounds   = 4;
  localparam int unsigned rate_hold     = 2 * led_pkg::rate_window_cycles + 4;
  localparam int unsigned test_cycles   = reset_cycles + error_cycles + 2 * nolink_cycles +
                                          2 * cylon_cycles + strobe_count * (max_gap + 2) +
                                          led_pkg::flash_cycles + 4 + rate_rounds * rate_hold;
  localparam int unsigned margin_cycles = 200;

  logic clock;
  logic rst_n;
  logic mmcm_locked;
  logic ttc_l1a;
  logic ttc_bc0;
  logic ttc_resync;
  logic vfat_reset;
  logic gbt_rxready;
  logic gbt_rxvalid;
  logic gbt_link_ready;
  logic gbt_request_received;
  led_pkg::cluster_count_t cluster_count;
  led_pkg::rate_t          cluster_rate;
  led_pkg::led_word_t      led_out;

  logic [31:0] rng;          // xorshift state
  int unsigned tb_errors;    // value mismatches found here
  int unsigned gap;

  initial clock = 1'b0;
  always #(clock_period / 2) clock = ~clock;

  led_control dut0 (
    .clock                (clock),
    .rst_n                (rst_n),
    .mmcm_locked          (mmcm_locked),
    .ttc_l1a              (ttc_l1a),
    .ttc_bc0              (ttc_bc0),
    .ttc_resync           (ttc_resync),
    .vfat_reset           (vfat_reset),
    .gbt_rxready          (gbt_rxready),
    .gbt_rxvalid          (gbt_rxvalid),
    .gbt_link_ready       (gbt_link_ready),
    .gbt_request_received (gbt_request_received),
    .cluster_count        (cluster_count),
    .cluster_rate         (cluster_rate),
    .led_out              (led_out)
  );

  bind led_control led_control_assertions u_assertions (
    .clock                (clock),
    .rst_n                (rst_n),
    .mmcm_locked          (mmcm_locked),
    .gbt_rxready          (gbt_rxready),
    .gbt_rxvalid          (gbt_rxvalid),
    .ttc_l1a              (ttc_l1a),
    .ttc_bc0              (ttc_bc0),
    .ttc_resync           (ttc_resync),
    .vfat_reset           (vfat_reset),
    .gbt_request_received (gbt_request_received),
    .cluster_count        (cluster_count),
    .led_out              (led_out)
  );

  // ------------------------------
  // helpers
  // ------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // doubling threshold per segment, lowest at bar_base
  function automatic led_pkg::bar_t expected_bar(input led_pkg::rate_t rate);
    led_pkg::bar_t  b;
    led_pkg::rate_t limit;
    limit = led_pkg::bar_base;
    for (int i = 0; i < 8; i++) begin
      b[i]  = (rate >= limit);
      limit = limit << 1;
    end
    return b;
  endfunction

  // one-cycle pulse, 0 l1a, 1 bc0, 2 resync, 3 vfat_reset, else gbt request
  task automatic pulse_strobe(input int unsigned which);
    case (which)
      0:       ttc_l1a              = 1'b1;
      1:       ttc_bc0              = 1'b1;
      2:       ttc_resync           = 1'b1;
      3:       vfat_reset           = 1'b1;
      default: gbt_request_received = 1'b1;
    endcase
    @(negedge clock);
    ttc_l1a              = 1'b0;
    ttc_bc0              = 1'b0;
    ttc_resync           = 1'b0;
    vfat_reset           = 1'b0;
    gbt_request_received = 1'b0;
  endtask

  // hold c over two windows, then compare rate and bar
  task automatic check_rate(input led_pkg::cluster_count_t c);
    led_pkg::rate_t expected;
    led_pkg::bar_t  bar_exp;
    cluster_count = c;
    repeat (rate_hold) @(negedge clock);
    expected = led_pkg::rate_t'(c) * led_pkg::rate_window_cycles;
    bar_exp  = expected_bar(expected);
    if (cluster_rate !== expected) begin
      tb_errors++;
      $display("Error at %0t: cluster_rate = %0d, expected %0d", $time, cluster_rate, expected);
    end
    if (led_out[7:0] !== bar_exp) begin
      tb_errors++;
      $display("Error at %0t: led_out[7:0] = %b, expected %b", $time, led_out[7:0], bar_exp);
    end
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------

  initial begin
    rst_n                = 1'b0;
    mmcm_locked          = 1'b0;
    gbt_rxready          = 1'b0;
    gbt_rxvalid          = 1'b0;
    ttc_l1a              = 1'b0;
    ttc_bc0              = 1'b0;
    ttc_resync           = 1'b0;
    vfat_reset           = 1'b0;
    gbt_link_ready       = 1'b0;
    gbt_request_received = 1'b0;
    cluster_count        = '0;
    rng                  = 32'h45e968fc;
    tb_errors            = 0;
    repeat (reset_cycles) @(negedge clock);
    rst_n = 1'b1;
    if (led_out !== '0) begin
      tb_errors++;
      $display("Error at %0t: led_out = %h, expected %h", $time, led_out, 16'h0000);
    end
    if (cluster_rate !== '0) begin
      tb_errors++;
      $display("Error at %0t: cluster_rate = %0d, expected %0d", $time, cluster_rate, 0);
    end
    repeat (error_cycles) @(negedge clock);      // clock manager still unlocked
    mmcm_locked = 1'b1;
    gbt_rxvalid = 1'b1;
    repeat (nolink_cycles) @(negedge clock);     // rxready missing
    gbt_rxready = 1'b1;
    gbt_rxvalid = 1'b0;
    repeat (nolink_cycles) @(negedge clock);     // rxvalid missing
    gbt_rxvalid    = 1'b1;
    gbt_link_ready = 1'b1;
    repeat (cylon_cycles) @(negedge clock);
    pulse_strobe(2);                              // resync, scanner again
    repeat (cylon_cycles) @(negedge clock);
    cluster_count = 8'd1;                         // first cluster, normal mode
    for (int k = 0; k < strobe_count; k++) begin
      rng = xorshift32(rng);
      gap = rng % max_gap + 1;
      repeat (gap) @(negedge clock);
      rng = xorshift32(rng);
      pulse_strobe(rng % 5);
    end
    repeat (led_pkg::flash_cycles + 4) @(negedge clock);
    // first_seen is sticky, so a zero count stays in normal mode
    for (int r = 0; r < rate_rounds; r++) begin
      rng = xorshift32(rng);
      if (r == 0) begin
        check_rate(8'd0);                         // empty windows, dark bar
      end else if (r == 1) begin
        check_rate(8'd1);                         // top segment still off
      end else begin
        check_rate(rng[7:0]);
      end
    end
    $display("errors: testbench checks %0d, assertion failures %0d",
             tb_errors, dut0.u_assertions.fail_count);
    if (tb_errors == 0 && dut0.u_assertions.fail_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((test_cycles + margin_cycles) * clock_period);
    $display("watchdog: run did not finish within %0d cycles", test_cycles + margin_cycles);
    $display("tests failed");
    $finish;
  end

endmodule

//--- list.f
led_pkg.sv
led_flash_if.sv
event_flash.sv
rate_meter.sv
blink_gen.sv
led_select.sv
led_control.sv
led_control_assertions.sv
tb_led_control.sv

//--- Makefile
# Verilator build and run for the LED subsystem testbench

TOP       ?= tb_led_control
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
SIM_ARGS  ?= +verilator+error+limit+100000

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) $(SIM_ARGS) | tee $(LOG)
	@grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
